// ==== bench/fpa_tb.sv ====
/*
	F-PA datapath testbench
	directed tests against a T/M/C model with T read back over the ZP bus
*/

`timescale 1ns/1ps

module fpa_tb;

	localparam int n_arith = 8;
	// per-test cycle budget for reset and load, arith, shifts, M path, readout and sign
	localparam int timeout_cycles = 2 * (20 + n_arith * 12 + 56 + 14 + 12 + 32);

	logic                 strob_fp_;
	logic                 _0_t_;
	fpa_pkg::fpa_op_e     op;
	logic [0:15]          w;
	logic                 shift_in;
	logic                 carry_in;
	fpa_pkg::zp_sel_e     zp_sel;
	fpa_pkg::fpa_flags_t  flags;
	logic [0:7]           d;
	logic [0:15]          zp;
	fpa_pkg::fpa_status_t status;

	// reference copies of T, M and C
	logic [0:39] mt;
	logic [0:39] mm;
	logic [0:39] mc;
	integer      seed;
	int          n_checks;
	int          n_errors;
	int          cycles;

	fpa_top u_dut (
		.strob_fp_ (strob_fp_),
		._0_t_     (_0_t_),
		.op        (op),
		.w         (w),
		.shift_in  (shift_in),
		.carry_in  (carry_in),
		.zp_sel    (zp_sel),
		.flags     (flags),
		.d         (d),
		.zp        (zp),
		.status    (status)
	);

	initial begin
		strob_fp_ = 1'b0;
		forever #20 strob_fp_ = ~strob_fp_;
	end

	initial begin
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge strob_fp_);
			cycles = cycles + 1;
		end
		$display("timeout after %0d cycles, the tests did not finish", cycles);
		$display("Result: FAILED");
		$finish;
	end

	function automatic logic [0:39] sum_model(input logic sub, input logic ci);
		logic [0:39] b;
		logic [40:0] full;
		b = sub ? ~mc : mc;
		full = {1'b0, mt} + {1'b0, b} + {40'd0, ci};
		return full[39:0];
	endfunction

	function automatic fpa_pkg::fpa_status_t expect_status(input logic sub, input logic ci);
		fpa_pkg::fpa_status_t s;
		logic [0:39] b;
		logic [40:0] lo40;
		logic [24:0] lo24;
		logic [8:0]  lo8;
		b = sub ? ~mc : mc;
		// carry out of each low group from group-wide sums
		lo8  = {1'b0, mt[32:39]} + {1'b0, b[32:39]} + {8'd0, ci};
		lo24 = {1'b0, mt[16:39]} + {1'b0, b[16:39]} + {24'd0, ci};
		lo40 = {1'b0, mt} + {1'b0, b} + {40'd0, ci};
		s.z_0_1    = (mt[0:1] == 2'b00);
		s.z_2_7    = (mt[2:7] == 6'd0);
		s.z_8_15   = (mt[8:15] == 8'd0);
		s.z_16_23  = (mt[16:23] == 8'd0);
		s.z_24_31  = (mt[24:31] == 8'd0);
		s.z_32_39  = (mt[32:39] == 8'd0);
		s.cy0      = lo40[40];
		s.cy16     = lo24[24];
		s.cy32     = lo8[8];
		s.t0_eq_c0 = (mt[0] == mc[0]);
		s.t0_ne_t1 = (mt[0] != mt[1]);
		s.c0_eq_c1 = (mc[0] == mc[1]);
		s.t0       = mt[0];
		s.m0       = mm[0];
		s.c39      = mc[39];
		return s;
	endfunction

	function automatic void model_step(input fpa_pkg::fpa_op_e o, input logic [0:15] wv,
		input logic si, input logic ci);
		case (o)
			fpa_pkg::op_t_from_w: mt = {wv, wv, wv[0:7]};
			fpa_pkg::op_t_from_m: mt = mm;
			fpa_pkg::op_t_clear:  mt = '0;
			fpa_pkg::op_add:      mt = sum_model(1'b0, ci);
			fpa_pkg::op_sub:      mt = sum_model(1'b1, ci);
			fpa_pkg::op_t_shr:    mt = {si, mt[0:38]};
			fpa_pkg::op_t_shl:    mt = {mt[1:39], mm[0]};
			fpa_pkg::op_m_from_t: mm = mt;
			fpa_pkg::op_m_shr:    mm = {si, mm[0:38]};
			fpa_pkg::op_c_from_t: mc = mt;
			fpa_pkg::op_c_shr:    mc = {mc[0], mc[0:38]};
			default:              mt = mt;
		endcase
	endfunction

	task automatic check_zp(input string name, input logic [0:15] got, input logic [0:15] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAIL t=%0t %s exp %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_status(input string name, input fpa_pkg::fpa_status_t got,
		input fpa_pkg::fpa_status_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAIL t=%0t %s exp %b got %b", $time, name, exp, got);
		end
	endtask

	// one opcode per edge
	// status is checked while the opcode is present
	task automatic apply(input fpa_pkg::fpa_op_e o, input logic [0:15] wv, input logic si,
		input logic ci);
		@(posedge strob_fp_);
		op       <= o;
		w        <= wv;
		shift_in <= si;
		carry_in <= ci;
		@(negedge strob_fp_);
		check_status("status", status, expect_status(o == fpa_pkg::op_sub, ci));
		model_step(o, wv, si, ci);
	endtask

	task automatic read_slice(input fpa_pkg::zp_sel_e sel, input logic [0:15] exp,
		input string name);
		@(posedge strob_fp_);
		op       <= fpa_pkg::op_nop;
		carry_in <= 1'b0;
		zp_sel   <= sel;
		@(negedge strob_fp_);
		check_zp(name, zp, exp);
	endtask

	task automatic read_t();
		read_slice(fpa_pkg::zp_t_hi, mt[0:15], "zp T[0:15]");
		read_slice(fpa_pkg::zp_t_mid, mt[16:31], "zp T[16:31]");
		read_slice(fpa_pkg::zp_t_lo, {mt[32:39], d}, "zp T[32:39]");
	endtask

	task automatic reset_and_load();
		@(negedge strob_fp_);
		// all zero groups set, no carries, sign compares of zero words
		check_status("status", status, fpa_pkg::fpa_status_t'(15'b111111_000_101_000));
		read_t();
		apply(fpa_pkg::op_t_from_w, 16'ha5c3, 1'b0, 1'b0);
		read_t();
	endtask

	task automatic add_and_sub();
		int i;
		int rnd;
		for (i = 0; i < n_arith; i++) begin
			rnd = $random(seed);
			apply(fpa_pkg::op_t_from_w, rnd[15:0], 1'b0, 1'b0);
			apply(fpa_pkg::op_c_from_t, 16'h0000, 1'b0, 1'b0);
			apply(fpa_pkg::op_t_from_w, rnd[31:16], 1'b0, 1'b0);
			rnd = $random(seed);
			apply(fpa_pkg::op_add, 16'h0000, 1'b0, rnd[0]);
			read_t();
			apply(fpa_pkg::op_sub, 16'h0000, 1'b0, rnd[1]);
			read_t();
		end
	endtask

	task automatic shift_paths();
		int i;
		apply(fpa_pkg::op_t_from_w, 16'h8001, 1'b0, 1'b0);
		for (i = 0; i < 3; i++) begin
			apply(fpa_pkg::op_t_shr, 16'h0000, i != 1, 1'b0);
			read_t();
		end
		apply(fpa_pkg::op_m_from_t, 16'h0000, 1'b0, 1'b0);
		for (i = 0; i < 3; i++) begin
			// drop M bit 0 before the last left shift
			if (i == 2)
				apply(fpa_pkg::op_m_shr, 16'h0000, 1'b0, 1'b0);
			apply(fpa_pkg::op_t_shl, 16'h0000, 1'b0, 1'b0);
			read_t();
		end
		for (i = 0; i < 2; i++) begin
			apply(fpa_pkg::op_t_from_w, (i == 0) ? 16'hc0f0 : 16'h3a5c, 1'b0, 1'b0);
			apply(fpa_pkg::op_c_from_t, 16'h0000, 1'b0, 1'b0);
			repeat (3) apply(fpa_pkg::op_c_shr, 16'h0000, 1'b0, 1'b0);
			apply(fpa_pkg::op_t_clear, 16'h0000, 1'b0, 1'b0);
			apply(fpa_pkg::op_add, 16'h0000, 1'b0, 1'b0);
			read_t();
		end
	endtask

	task automatic m_round_trip();
		int rnd;
		rnd = $random(seed);
		apply(fpa_pkg::op_t_from_w, rnd[15:0], 1'b0, 1'b0);
		apply(fpa_pkg::op_m_from_t, 16'h0000, 1'b0, 1'b0);
		apply(fpa_pkg::op_m_shr, 16'h0000, 1'b1, 1'b0);
		apply(fpa_pkg::op_m_shr, 16'h0000, 1'b0, 1'b0);
		apply(fpa_pkg::op_t_clear, 16'h0000, 1'b0, 1'b0);
		read_t();
		apply(fpa_pkg::op_t_from_m, 16'h0000, 1'b0, 1'b0);
		read_t();
	endtask

	task automatic zp_readout();
		int i;
		int rnd;
		apply(fpa_pkg::op_t_from_w, 16'h5a3c, 1'b0, 1'b0);
		for (i = 0; i < 4; i++) begin
			rnd = $random(seed);
			@(posedge strob_fp_);
			op     <= fpa_pkg::op_nop;
			zp_sel <= fpa_pkg::zp_flags;
			flags  <= fpa_pkg::fpa_flags_t'(rnd[3:0]);
			d      <= rnd[11:4];
			@(negedge strob_fp_);
			check_zp("zp flags", zp, {rnd[3:0], 12'h000});
			read_slice(fpa_pkg::zp_t_lo, {mt[32:39], rnd[11:4]}, "zp T[32:39] with d");
		end
	endtask

	task automatic sign_compares();
		logic [0:15] pat [0:5];
		int          i;
		pat = '{16'h0000, 16'h4000, 16'h0100, 16'h0080, 16'hc000, 16'h8000};
		for (i = 0; i < 6; i++) begin
			// C keeps the previous pattern so the compares see both signs
			apply(fpa_pkg::op_c_from_t, 16'h0000, 1'b0, 1'b0);
			apply(fpa_pkg::op_t_from_w, pat[i], 1'b0, 1'b0);
			read_t();
		end
		apply(fpa_pkg::op_nop, 16'h0000, 1'b0, 1'b0);
	endtask

	initial begin
		seed     = 32'hc158;
		n_checks = 0;
		n_errors = 0;
		mt       = '0;
		mm       = '0;
		mc       = '0;
		_0_t_    <= 1'b0;
		op       <= fpa_pkg::op_nop;
		w        <= '0;
		shift_in <= 1'b0;
		carry_in <= 1'b0;
		zp_sel   <= fpa_pkg::zp_t_hi;
		flags    <= '0;
		d        <= '0;
		repeat (8) @(posedge strob_fp_);
		_0_t_ <= 1'b1;
		reset_and_load();
		add_and_sub();
		shift_paths();
		m_round_trip();
		zp_readout();
		sign_compares();
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
rtl/fpa_pkg.sv
rtl/fpa_decode.sv
rtl/fpa_t_reg.sv
rtl/fpa_mc_regs.sv
rtl/fpa_adder.sv
rtl/fpa_readout.sv
rtl/fpa_top.sv
bench/fpa_tb.sv

// ==== rtl/fpa_adder.sv ====
/*
	F-PA adder
	40-bit T plus C or T plus ~C with carry in, and group carries
	out of bits 32:39, 16:39 and the whole word
*/

`timescale 1ns/1ps

module fpa_adder (
	input  fpa_pkg::alu_op_e          alu_op,
	input  logic [0:fpa_pkg::fpa_w-1] t,
	input  logic [0:fpa_pkg::fpa_w-1] c,
	input  logic                      carry_in,
	output logic [0:fpa_pkg::fpa_w-1] sum,
	output logic                      cy0,
	output logic                      cy16,
	output logic                      cy32
);

	logic [0:fpa_pkg::fpa_w-1] b;
	logic [0:fpa_pkg::fpa_w]   full;

	// second operand, complemented for subtract
	assign b = (alu_op == fpa_pkg::alu_sub) ? ~c : c;

	// bit 0 is the MSB, so full[0] is the word carry out
	assign full = {1'b0, t} + {1'b0, b} + {{fpa_pkg::fpa_w{1'b0}}, carry_in};
	assign sum  = full[1:fpa_pkg::fpa_w];
	assign cy0  = full[0];

	/*
		group carries recovered from the sum:
		carry into bit k is t[k] ^ b[k] ^ sum[k]
	*/
	assign cy16 = t[15] ^ b[15] ^ sum[15];
	assign cy32 = t[31] ^ b[31] ^ sum[31];

endmodule

// ==== rtl/fpa_decode.sv ====
/*
	F-PA opcode decoder
	turns one opcode per cycle into the register and adder controls
*/

`timescale 1ns/1ps

module fpa_decode (
	input  fpa_pkg::fpa_op_e  op,
	output fpa_pkg::fpa_ctl_t ctl
);

	always_comb begin
		// everything holds unless the opcode says otherwise
		ctl.t_op   = fpa_pkg::reg_hold;
		ctl.k_src  = fpa_pkg::k_sum;
		ctl.m_op   = fpa_pkg::reg_hold;
		ctl.c_op   = fpa_pkg::reg_hold;
		ctl.alu_op = fpa_pkg::alu_add;

		case (op)
			fpa_pkg::op_t_from_w: begin
				ctl.t_op  = fpa_pkg::reg_load;
				ctl.k_src = fpa_pkg::k_w;
			end
			fpa_pkg::op_t_from_m: begin
				ctl.t_op  = fpa_pkg::reg_load;
				ctl.k_src = fpa_pkg::k_m;
			end
			fpa_pkg::op_t_clear: begin
				ctl.t_op  = fpa_pkg::reg_load;
				ctl.k_src = fpa_pkg::k_zero;
			end
			fpa_pkg::op_add: begin
				ctl.t_op  = fpa_pkg::reg_load;
				ctl.k_src = fpa_pkg::k_sum;
			end
			fpa_pkg::op_sub: begin
				// T + ~C + carry_in
				ctl.t_op   = fpa_pkg::reg_load;
				ctl.k_src  = fpa_pkg::k_sum;
				ctl.alu_op = fpa_pkg::alu_sub;
			end
			fpa_pkg::op_t_shr: begin
				ctl.t_op = fpa_pkg::reg_shr;
			end
			fpa_pkg::op_t_shl: begin
				ctl.t_op = fpa_pkg::reg_shl;
			end
			fpa_pkg::op_m_from_t: begin
				ctl.m_op = fpa_pkg::reg_load;
			end
			fpa_pkg::op_m_shr: begin
				ctl.m_op = fpa_pkg::reg_shr;
			end
			fpa_pkg::op_c_from_t: begin
				ctl.c_op = fpa_pkg::reg_load;
			end
			fpa_pkg::op_c_shr: begin
				ctl.c_op = fpa_pkg::reg_shr;
			end
			default: begin
				// op_nop and unused codes
				ctl.t_op = fpa_pkg::reg_hold;
			end
		endcase
	end

endmodule

// ==== rtl/fpa_mc_regs.sv ====
/*
	F-PA M and C registers
	M is the multiplier/quotient register, C the adder operand
*/

`timescale 1ns/1ps

module fpa_mc_regs (
	input  logic                      strob_fp_,
	input  logic                      _0_t_,
	input  fpa_pkg::fpa_ctl_t         ctl,
	input  logic [0:fpa_pkg::fpa_w-1] t,
	input  logic                      shift_in,
	output logic [0:fpa_pkg::fpa_w-1] m,
	output logic [0:fpa_pkg::fpa_w-1] c
);

	// M register
	always_ff @(posedge strob_fp_ or negedge _0_t_) begin
		if (!_0_t_) begin
			m <= '0;
		end else begin
			case (ctl.m_op)
				fpa_pkg::reg_load: m <= t;
				fpa_pkg::reg_shr:  m <= {shift_in, m[0:fpa_pkg::fpa_w-2]};
				default:           m <= m;
			endcase
		end
	end

	// C register, arithmetic right shift keeps the sign
	always_ff @(posedge strob_fp_ or negedge _0_t_) begin
		if (!_0_t_) begin
			c <= '0;
		end else begin
			case (ctl.c_op)
				fpa_pkg::reg_load: c <= t;
				fpa_pkg::reg_shr:  c <= {c[0], c[0:fpa_pkg::fpa_w-2]};
				default:           c <= c;
			endcase
		end
	end

endmodule

// ==== rtl/fpa_pkg.sv ====
/*
	F-PA shared definitions
	word format constants, opcode and control encodings,
	control and status bundles for the FPU arithmetic datapath
*/

package fpa_pkg;

	// machine word and bus widths
	parameter int fpa_w = 40;
	parameter int bus_w = 16;

	// one opcode per strobe
	typedef enum logic [3:0] {
		op_nop      = 4'h0,
		op_t_from_w = 4'h1,
		op_t_from_m = 4'h2,
		op_t_clear  = 4'h3,
		op_add      = 4'h4,
		op_sub      = 4'h5,
		op_t_shr    = 4'h6,
		op_t_shl    = 4'h7,
		op_m_from_t = 4'h8,
		op_m_shr    = 4'h9,
		op_c_from_t = 4'ha,
		op_c_shr    = 4'hb
	} fpa_op_e;

	// per-register action
	typedef enum logic [1:0] {
		reg_hold = 2'b00,
		reg_shr  = 2'b01,
		reg_shl  = 2'b10,
		reg_load = 2'b11
	} reg_op_e;

	// K bus source for T loads
	typedef enum logic [1:0] {
		k_sum  = 2'b00,
		k_m    = 2'b01,
		k_w    = 2'b10,
		k_zero = 2'b11
	} k_src_e;

	typedef enum logic {
		alu_add = 1'b0,
		alu_sub = 1'b1
	} alu_op_e;

	// ZP bus readout select
	typedef enum logic [1:0] {
		zp_t_hi  = 2'b00,
		zp_t_mid = 2'b01,
		zp_t_lo  = 2'b10,
		zp_flags = 2'b11
	} zp_sel_e;

	// flag bits from the sibling flag unit
	typedef struct packed {
		logic z;
		logic m;
		logic v;
		logic c;
	} fpa_flags_t;

	typedef struct packed {
		reg_op_e t_op;
		k_src_e  k_src;
		reg_op_e m_op;
		reg_op_e c_op;
		alu_op_e alu_op;
	} fpa_ctl_t;

	// status word for the sequencer
	typedef struct packed {
		logic z_0_1;
		logic z_2_7;
		logic z_8_15;
		logic z_16_23;
		logic z_24_31;
		logic z_32_39;
		logic cy0;
		logic cy16;
		logic cy32;
		logic t0_eq_c0;
		logic t0_ne_t1;
		logic c0_eq_c1;
		logic t0;
		logic m0;
		logic c39;
	} fpa_status_t;

endpackage

// ==== rtl/fpa_readout.sv ====
/*
	F-PA readout
	ZP bus slice mux, T zero-group detectors and sign compares
*/

`timescale 1ns/1ps

module fpa_readout (
	input  fpa_pkg::zp_sel_e           zp_sel,
	input  fpa_pkg::fpa_flags_t        flags,
	input  logic [0:7]                 d,
	input  logic [0:fpa_pkg::fpa_w-1]  t,
	input  logic [0:fpa_pkg::fpa_w-1]  m,
	input  logic [0:fpa_pkg::fpa_w-1]  c,
	input  logic                       cy0,
	input  logic                       cy16,
	input  logic                       cy32,
	output logic [0:fpa_pkg::bus_w-1]  zp,
	output fpa_pkg::fpa_status_t       status
);

	always_comb begin
		case (zp_sel)
			fpa_pkg::zp_t_hi:  zp = t[0:15];
			fpa_pkg::zp_t_mid: zp = t[16:31];
			fpa_pkg::zp_t_lo:  zp = {t[32:39], d};
			default:           zp = {flags, 12'd0};
		endcase
	end

	// zero groups as the sequencer sees them
	assign status.z_0_1   = ~|t[0:1];
	assign status.z_2_7   = ~|t[2:7];
	assign status.z_8_15  = ~|t[8:15];
	assign status.z_16_23 = ~|t[16:23];
	assign status.z_24_31 = ~|t[24:31];
	assign status.z_32_39 = ~|t[32:39];

	assign status.cy0  = cy0;
	assign status.cy16 = cy16;
	assign status.cy32 = cy32;

	// sign compares
	assign status.t0_eq_c0 = ~(t[0] ^ c[0]);
	assign status.t0_ne_t1 = t[0] ^ t[1];
	assign status.c0_eq_c1 = ~(c[0] ^ c[1]);

	assign status.t0  = t[0];
	assign status.m0  = m[0];
	assign status.c39 = c[fpa_pkg::fpa_w-1];

endmodule

// ==== rtl/fpa_t_reg.sv ====
/*
	F-PA T accumulator
	three chained segments 0:15, 16:31, 32:39 fed from the K bus
*/

`timescale 1ns/1ps

module fpa_t_reg (
	input  logic                         strob_fp_,
	input  logic                         _0_t_,
	input  fpa_pkg::fpa_ctl_t            ctl,
	input  logic [0:fpa_pkg::bus_w-1]    w,
	input  logic [0:fpa_pkg::fpa_w-1]    sum,
	input  logic [0:fpa_pkg::fpa_w-1]    m,
	input  logic                         shift_in,
	output logic [0:fpa_pkg::fpa_w-1]    t
);

	logic [0:fpa_pkg::fpa_w-1] k;

	// segment registers
	logic [0:15] t_a;
	logic [0:15] t_b;
	logic [0:7]  t_c;

	// K bus source mux
	always_comb begin
		case (ctl.k_src)
			fpa_pkg::k_sum: k = sum;
			fpa_pkg::k_m:   k = m;
			fpa_pkg::k_w:   k = {w, w, w[0:7]};
			default:        k = '0;
		endcase
	end

	// bits cross segment boundaries on shifts
	always_ff @(posedge strob_fp_ or negedge _0_t_) begin
		if (!_0_t_) begin
			t_a <= '0;
			t_b <= '0;
			t_c <= '0;
		end else begin
			case (ctl.t_op)
				fpa_pkg::reg_shr: begin
					t_a <= {shift_in, t_a[0:14]};
					t_b <= {t_a[15], t_b[0:14]};
					t_c <= {t_b[15], t_c[0:6]};
				end
				fpa_pkg::reg_shl: begin
					// low end fills from M bit 0
					t_a <= {t_a[1:15], t_b[0]};
					t_b <= {t_b[1:15], t_c[0]};
					t_c <= {t_c[1:7], m[0]};
				end
				fpa_pkg::reg_load: begin
					t_a <= k[0:15];
					t_b <= k[16:31];
					t_c <= k[32:39];
				end
				default: begin
					t_a <= t_a;
					t_b <= t_b;
					t_c <= t_c;
				end
			endcase
		end
	end

	assign t = {t_a, t_b, t_c};

endmodule

// ==== rtl/fpa_top.sv ====
/*
	F-PA arithmetic datapath top
	decoder, T/M/C registers, adder and ZP readout
*/

`timescale 1ns/1ps

module fpa_top (
	input  logic                      strob_fp_,
	input  logic                      _0_t_,
	input  fpa_pkg::fpa_op_e          op,
	input  logic [0:fpa_pkg::bus_w-1] w,
	input  logic                      shift_in,
	input  logic                      carry_in,
	input  fpa_pkg::zp_sel_e          zp_sel,
	input  fpa_pkg::fpa_flags_t       flags,
	input  logic [0:7]                d,
	output logic [0:fpa_pkg::bus_w-1] zp,
	output fpa_pkg::fpa_status_t      status
);

	fpa_pkg::fpa_ctl_t         ctl;
	logic [0:fpa_pkg::fpa_w-1] t;
	logic [0:fpa_pkg::fpa_w-1] m;
	logic [0:fpa_pkg::fpa_w-1] c;
	logic [0:fpa_pkg::fpa_w-1] sum;
	logic                      cy0;
	logic                      cy16;
	logic                      cy32;

	fpa_decode u_decode (
		.op  (op),
		.ctl (ctl)
	);

	fpa_t_reg u_t_reg (
		.strob_fp_ (strob_fp_),
		._0_t_     (_0_t_),
		.ctl       (ctl),
		.w         (w),
		.sum       (sum),
		.m         (m),
		.shift_in  (shift_in),
		.t         (t)
	);

	fpa_mc_regs u_mc_regs (
		.strob_fp_ (strob_fp_),
		._0_t_     (_0_t_),
		.ctl       (ctl),
		.t         (t),
		.shift_in  (shift_in),
		.m         (m),
		.c         (c)
	);

	// adder function follows the current opcode
	fpa_adder u_adder (
		.alu_op   (ctl.alu_op),
		.t        (t),
		.c        (c),
		.carry_in (carry_in),
		.sum      (sum),
		.cy0      (cy0),
		.cy16     (cy16),
		.cy32     (cy32)
	);

	fpa_readout u_readout (
		.zp_sel (zp_sel),
		.flags  (flags),
		.d      (d),
		.t      (t),
		.m      (m),
		.c      (c),
		.cy0    (cy0),
		.cy16   (cy16),
		.cy32   (cy32),
		.zp     (zp),
		.status (status)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the F-PA datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module fpa_tb -o fpa_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/fpa_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
	exit 0
fi
exit 1
